//--- flist.f
hw/pci_bus_pkg.sv
hw/wb_bus_pkg.sv
hw/pci_pads.sv
hw/pci_target.sv
hw/pci_parity_check.sv
hw/wb_master.sv
hw/pci_wb_bridge.sv
bench/wb_slave_model.sv
bench/tb_pci_wb_bridge.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_pci_wb_bridge
RTL_TOP     ?= pci_wb_bridge
FLIST       ?= flist.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing
PASS_STRING ?= *** PASSED ***

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_STRING)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_pci_wb_bridge.sv
`timescale 1ns/1ps

module tb_pci_wb_bridge;

   import pci_bus_pkg::*;
   import wb_bus_pkg::*;

   localparam logic [11:0] ERR_OFS = 12'hFF0;
   localparam logic [11:0] RTY_OFS = 12'hFF4;
   localparam int N_RANDOM = 12;
   localparam int N_ACCESS = N_RANDOM + 14;
   localparam int TIMEOUT_CYCLES = 40 * N_ACCESS;

   localparam logic [2:0] T_ACK    = 3'd0;
   localparam logic [2:0] T_DISC   = 3'd1;
   localparam logic [2:0] T_RETRY  = 3'd2;
   localparam logic [2:0] T_ABORT  = 3'd3;
   localparam logic [2:0] T_MABORT = 3'd4;

   typedef struct packed {
      logic [2:0] term;
      wb_adr_t    adr;
      wb_sel_t    sel;
      wb_dat_t    rdata;
   } expect_t;

   logic     pci_clk = 1'b0;
   logic     reset_i;
   int       cycle_no = 0;

   wire [31:0] pci_ad;
   wire [3:0]  pci_cbe;
   wire        frame_n, irdy_n, trdy_n, devsel_n, stop_n, par, perr_n, serr_n;

   wire        wbm_cyc, wbm_stb, wbm_we, wbm_ack, wbm_err, wbm_rty;
   wb_adr_t    wbm_adr;
   wb_dat_t    wbm_dat_o;
   wb_dat_t    wbm_dat_i;
   wb_sel_t    wbm_sel;

   // Initiator drivers
   pci_ad_t  tb_ad;
   pci_cbe_t tb_cbe;
   logic     tb_ad_oe, tb_cbe_oe, tb_ctl_oe, tb_frame_n, tb_irdy_n;
   logic     tb_par, tb_par_oe, par_next, par_oe_next;
   logic     ad_is_addr, flip_addr, flip_data;

   // Current access, expected and observed
   expect_t  cur_exp;
   logic     cur_we, cur_bad_apar, cur_bad_dpar;
   pci_ad_t  cur_wdata;
   pci_cbe_t cur_be_n;
   logic [2:0] obs_term;
   int       obs_a, obs_d, obs_devsel;
   pci_ad_t  obs_rdata;
   logic     obs_par;
   event     result_ev;

   int       perr_lows[$];
   int       serr_lows[$];
   wb_req_t  wb_seen[$];
   wb_dat_t  shadow [0:1023];

   assign pci_ad   = tb_ad_oe  ? tb_ad      : 'z;
   assign pci_cbe  = tb_cbe_oe ? tb_cbe     : 'z;
   assign frame_n  = tb_ctl_oe ? tb_frame_n : 1'bz;
   assign irdy_n   = tb_ctl_oe ? tb_irdy_n  : 1'bz;
   assign par      = tb_par_oe ? tb_par     : 1'bz;

   pullup (frame_n);
   pullup (irdy_n);
   pullup (trdy_n);
   pullup (devsel_n);
   pullup (stop_n);
   pullup (par);
   pullup (perr_n);
   pullup (serr_n);

   pci_wb_bridge pci_wb_bridge_inst (
      .pci_clk_i       (pci_clk),
      .reset_i         (reset_i),
      .pci_ad_io       (pci_ad),
      .pci_cbe_io      (pci_cbe),
      .pci_frame_n_io  (frame_n),
      .pci_irdy_n_io   (irdy_n),
      .pci_trdy_n_io   (trdy_n),
      .pci_devsel_n_io (devsel_n),
      .pci_stop_n_io   (stop_n),
      .pci_par_io      (par),
      .pci_perr_n_io   (perr_n),
      .pci_serr_n_o    (serr_n),
      .wbm_cyc_o       (wbm_cyc),
      .wbm_stb_o       (wbm_stb),
      .wbm_we_o        (wbm_we),
      .wbm_adr_o       (wbm_adr),
      .wbm_dat_o       (wbm_dat_o),
      .wbm_sel_o       (wbm_sel),
      .wbm_dat_i       (wbm_dat_i),
      .wbm_ack_i       (wbm_ack),
      .wbm_err_i       (wbm_err),
      .wbm_rty_i       (wbm_rty)
   );

   wb_slave_model #(.ERR_OFS(ERR_OFS), .RTY_OFS(RTY_OFS)) u_slave (
      .clk_i   (pci_clk),
      .reset_i (reset_i),
      .cyc_i   (wbm_cyc),
      .stb_i   (wbm_stb),
      .we_i    (wbm_we),
      .adr_i   (wbm_adr),
      .dat_i   (wbm_dat_o),
      .sel_i   (wbm_sel),
      .dat_o   (wbm_dat_i),
      .ack_o   (wbm_ack),
      .err_o   (wbm_err),
      .rty_o   (wbm_rty)
   );

   always #10 pci_clk = ~pci_clk;

   always @(posedge pci_clk) begin
      cycle_no <= cycle_no + 1;
      if (cycle_no >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $fatal(1, "timeout");
      end
   end

   // PAR follows each clock in which the initiator drove AD
   always @(posedge pci_clk) begin
      par_next    = ^{tb_ad, tb_cbe} ^ (ad_is_addr ? flip_addr : flip_data);
      par_oe_next = tb_ad_oe;
      #2;
      tb_par    = par_next;
      tb_par_oe = par_oe_next;
   end

   // Bus monitor
   always @(posedge pci_clk) begin
      if (!reset_i) begin
         if (perr_n === 1'b0) perr_lows.push_back(cycle_no);
         if (serr_n === 1'b0) serr_lows.push_back(cycle_no);
         if (wbm_cyc && wbm_stb && (wbm_ack || wbm_err || wbm_rty)) begin
            wb_seen.push_back({wbm_adr, wbm_dat_o, wbm_sel, wbm_we});
         end
      end
   end

   function automatic wb_dat_t fill_word(input int i);
      return 32'h5A5A_0000 ^ (32'(i) * 32'h0001_0003);
   endfunction

   function automatic expect_t pci_expect(input pci_ad_t addr, input logic [3:0] cmd,
                                          input pci_cbe_t be_n, input logic burst);
      expect_t e;
      e.adr   = addr & ~BAR_MASK;
      e.sel   = ~be_n;
      e.rdata = shadow[addr[11:2]];
      if ((addr & BAR_MASK) != BAR_BASE || (cmd != CMD_MEM_READ && cmd != CMD_MEM_WRITE)) begin
         e.term = T_MABORT;
      end else if (e.adr[11:0] == ERR_OFS) begin
         e.term = T_ABORT;
      end else if (e.adr[11:0] == RTY_OFS) begin
         e.term = T_RETRY;
      end else begin
         e.term = burst ? T_DISC : T_ACK;
      end
      return e;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "stopping at first error");
      end
   endtask

   // One memory access as PCI initiator, single phase or two-phase burst
   task automatic pci_access(input pci_ad_t addr, input logic [3:0] cmd, input pci_cbe_t be_n,
                             input pci_ad_t wdata, input logic burst,
                             input logic bad_apar, input logic bad_dpar);
      int   n;
      logic got_devsel;
      logic done;
      cur_exp      = pci_expect(addr, cmd, be_n, burst);
      cur_we       = (cmd == CMD_MEM_WRITE);
      cur_wdata    = wdata;
      cur_be_n     = be_n;
      cur_bad_apar = bad_apar;
      cur_bad_dpar = bad_dpar;
      perr_lows.delete();
      serr_lows.delete();
      wb_seen.delete();
      obs_devsel = -1;
      obs_d      = -1;
      flip_addr  = bad_apar;
      flip_data  = bad_dpar;
      ad_is_addr = 1'b1;
      tb_ad      = addr;
      tb_ad_oe   = 1'b1;
      tb_cbe     = cmd;
      tb_cbe_oe  = 1'b1;
      tb_frame_n = 1'b0;
      tb_irdy_n  = 1'b1;
      tb_ctl_oe  = 1'b1;
      @(posedge pci_clk);
      obs_a = cycle_no;
      #2;
      ad_is_addr = 1'b0;
      tb_cbe     = be_n;
      tb_irdy_n  = 1'b0;
      tb_frame_n = !burst;
      if (cur_we) tb_ad = wdata;
      else tb_ad_oe = 1'b0;
      n = 0;
      done = 1'b0;
      got_devsel = 1'b0;
      while (!done) begin
         @(posedge pci_clk);
         n++;
         if (devsel_n === 1'b0 && !got_devsel) begin
            got_devsel = 1'b1;
            obs_devsel = cycle_no;
         end
         if (trdy_n === 1'b0) begin
            done      = 1'b1;
            obs_d     = cycle_no;
            obs_rdata = pci_ad;
            obs_term  = (stop_n === 1'b0) ? T_DISC : T_ACK;
         end else if (stop_n === 1'b0) begin
            done     = 1'b1;
            obs_term = (devsel_n === 1'b0) ? T_RETRY : T_ABORT;
         end else if (!got_devsel && n >= 5) begin
            done     = 1'b1;
            obs_term = T_MABORT;
         end
      end
      #2;
      tb_frame_n = 1'b1;
      tb_irdy_n  = 1'b1;
      tb_ad_oe   = 1'b0;
      @(posedge pci_clk);
      obs_par = par;
      #2;
      tb_ctl_oe = 1'b0;
      tb_cbe_oe = 1'b0;
      // Leave room for PERR# at D+2 and D+3
      repeat (3) @(posedge pci_clk);
      -> result_ev;
      if (cur_we && (cur_exp.term == T_ACK || cur_exp.term == T_DISC)) begin
         for (int b = 0; b < 4; b++) begin
            if (!be_n[b]) shadow[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      repeat (2) @(posedge pci_clk);
      #2;
   endtask

   always begin
      @(result_ev);
      check_value("termination", 32'(obs_term), 32'(cur_exp.term));
      if (cur_exp.term != T_MABORT) begin
         check_value("devsel_edge", obs_devsel, obs_a + 2);
         check_value("wb_cycle_count", wb_seen.size(), 1);
         check_value("wbm_adr_o", wb_seen[0].adr, cur_exp.adr);
         check_value("wbm_sel_o", 32'(wb_seen[0].sel), 32'(cur_exp.sel));
         check_value("wbm_we_o", 32'(wb_seen[0].we), 32'(cur_we));
         if (cur_we) check_value("wbm_dat_o", wb_seen[0].dat, cur_wdata);
      end else begin
         check_value("wb_cycle_count", wb_seen.size(), 0);
      end
      if (!cur_we && cur_exp.term == T_ACK) begin
         check_value("pci_ad_io", obs_rdata, cur_exp.rdata);
         check_value("pci_par_io", 32'(obs_par), 32'(^{cur_exp.rdata, cur_be_n}));
      end
      if (cur_bad_apar) begin
         check_value("serr_low_count", serr_lows.size(), 1);
         check_value("serr_low_edge", serr_lows[0], obs_a + 2);
      end else begin
         check_value("serr_low_count", serr_lows.size(), 0);
      end
      if (cur_bad_dpar && cur_we && obs_d >= 0) begin
         check_value("perr_low_count", perr_lows.size(), 1);
         check_value("perr_low_edge", perr_lows[0], obs_d + 2);
      end else begin
         check_value("perr_low_count", perr_lows.size(), 0);
      end
   end

   initial begin
      pci_ad_t ofs;
      pci_cbe_t be;
      void'($urandom(47));
      reset_i    = 1'b1;
      tb_ad      = '0;
      tb_cbe     = '0;
      tb_ad_oe   = 1'b0;
      tb_cbe_oe  = 1'b0;
      tb_ctl_oe  = 1'b0;
      tb_frame_n = 1'b1;
      tb_irdy_n  = 1'b1;
      tb_par     = 1'b0;
      tb_par_oe  = 1'b0;
      ad_is_addr = 1'b0;
      flip_addr  = 1'b0;
      flip_data  = 1'b0;
      for (int i = 0; i < 1024; i++) shadow[i] = fill_word(i);
      repeat (4) @(posedge pci_clk);
      #2;
      reset_i = 1'b0;
      @(posedge pci_clk);
      #2;
      check_value("pci control pins", 32'({frame_n, irdy_n, trdy_n, devsel_n, stop_n,
                                           par, perr_n, serr_n}), 32'hFF);
      check_value("wbm_cyc_o", 32'(wbm_cyc), 0);

      pci_access(BAR_BASE | 32'h10, CMD_MEM_WRITE, 4'h0, 32'hCAFE_F00D, 0, 0, 0);
      pci_access(BAR_BASE | 32'h10, CMD_MEM_READ, 4'h0, '0, 0, 0, 0);
      for (int i = 0; i < N_RANDOM; i++) begin
         ofs = 32'($urandom_range(1000, 0)) << 2;
         be  = 4'($urandom_range(15, 0));
         if ($urandom_range(1, 0) == 1) begin
            pci_access(BAR_BASE | ofs, CMD_MEM_WRITE, be, $urandom, 0, 0, 0);
         end else begin
            pci_access(BAR_BASE | ofs, CMD_MEM_READ, be, '0, 0, 0, 0);
         end
      end

      // Misses
      pci_access(32'h9000_0010, CMD_MEM_WRITE, 4'h0, 32'h1234_5678, 0, 0, 0);
      pci_access(BAR_BASE | 32'h20, CMD_IO_READ, 4'h0, '0, 0, 0, 0);

      // Error and retry offsets
      pci_access(BAR_BASE | 32'(ERR_OFS), CMD_MEM_READ, 4'h0, '0, 0, 0, 0);
      pci_access(BAR_BASE | 32'(ERR_OFS), CMD_MEM_WRITE, 4'h0, 32'hDEAD_0001, 0, 0, 0);
      pci_access(BAR_BASE | 32'(RTY_OFS), CMD_MEM_WRITE, 4'h0, 32'hDEAD_0002, 0, 0, 0);
      pci_access(BAR_BASE | 32'(RTY_OFS), CMD_MEM_READ, 4'h0, '0, 0, 0, 0);
      // No stray write anywhere in the slave memory
      for (int i = 0; i < 1024; i++) begin
         check_value($sformatf("slave mem[%0d]", i), u_slave.mem[i], shadow[i]);
      end

      // Burst is disconnected after its first data phase
      pci_access(BAR_BASE | 32'h100, CMD_MEM_WRITE, 4'h0, 32'h0BAD_BEEF, 1, 0, 0);
      pci_access(BAR_BASE | 32'h100, CMD_MEM_READ, 4'h0, '0, 0, 0, 0);
      pci_access(BAR_BASE | 32'h104, CMD_MEM_READ, 4'h0, '0, 0, 0, 0);

      // Parity errors
      pci_access(BAR_BASE | 32'h200, CMD_MEM_WRITE, 4'h0, 32'h7777_1111, 0, 0, 1);
      pci_access(BAR_BASE | 32'h200, CMD_MEM_READ, 4'h3, '0, 0, 1, 0);
      pci_access(BAR_BASE | 32'h204, CMD_MEM_WRITE, 4'h5, 32'h2468_ACE0, 0, 0, 0);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- bench/wb_slave_model.sv
`timescale 1ns/1ps

module wb_slave_model #(
   parameter logic [11:0] ERR_OFS = 12'hFF0,
   parameter logic [11:0] RTY_OFS = 12'hFF4
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                cyc_i,
   input  logic                stb_i,
   input  logic                we_i,
   input  wb_bus_pkg::wb_adr_t adr_i,
   input  wb_bus_pkg::wb_dat_t dat_i,
   input  wb_bus_pkg::wb_sel_t sel_i,
   output wb_bus_pkg::wb_dat_t dat_o,
   output logic                ack_o,
   output logic                err_o,
   output logic                rty_o
);

   logic [31:0] mem [0:1023];
   logic [1:0]  wait_q;
   logic        active_q;
   logic [1:0]  waits;
   logic [9:0]  idx;

   assign idx = adr_i[11:2];

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 32'h5A5A_0000 ^ (32'(i) * 32'h0001_0003);
      end
   end

   // 0 to 3 wait states per cycle, response held for one clock
   always @(posedge clk_i) begin
      if (reset_i) begin
         ack_o    <= 1'b0;
         err_o    <= 1'b0;
         rty_o    <= 1'b0;
         active_q <= 1'b0;
         wait_q   <= '0;
      end else begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         rty_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !err_o && !rty_o) begin
            waits = active_q ? wait_q : 2'($urandom_range(3, 0));
            if (waits == 2'd0) begin
               active_q <= 1'b0;
               if (adr_i[11:0] == ERR_OFS) begin
                  err_o <= 1'b1;
               end else if (adr_i[11:0] == RTY_OFS) begin
                  rty_o <= 1'b1;
               end else begin
                  ack_o <= 1'b1;
                  dat_o <= mem[idx];
                  for (int b = 0; b < 4; b++) begin
                     if (we_i && sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                     end
                  end
               end
            end else begin
               active_q <= 1'b1;
               wait_q   <= waits - 2'd1;
            end
         end
      end
   end

endmodule

//--- hw/pci_wb_bridge.sv
`timescale 1ns/1ps

module pci_wb_bridge (
   input  logic                pci_clk_i,
   input  logic                reset_i,
   inout  wire  [31:0]         pci_ad_io,
   inout  wire  [3:0]          pci_cbe_io,
   inout  wire                 pci_frame_n_io,
   inout  wire                 pci_irdy_n_io,
   inout  wire                 pci_trdy_n_io,
   inout  wire                 pci_devsel_n_io,
   inout  wire                 pci_stop_n_io,
   inout  wire                 pci_par_io,
   inout  wire                 pci_perr_n_io,
   output wire                 pci_serr_n_o,
   output logic                wbm_cyc_o,
   output logic                wbm_stb_o,
   output logic                wbm_we_o,
   output wb_bus_pkg::wb_adr_t wbm_adr_o,
   output wb_bus_pkg::wb_dat_t wbm_dat_o,
   output wb_bus_pkg::wb_sel_t wbm_sel_o,
   input  wb_bus_pkg::wb_dat_t wbm_dat_i,
   input  logic                wbm_ack_i,
   input  logic                wbm_err_i,
   input  logic                wbm_rty_i
);

   import pci_bus_pkg::*;
   import wb_bus_pkg::*;

   pci_ad_t    ad;
   pci_cbe_t   cbe;
   logic       frame_n;
   logic       irdy_n;
   logic       par;
   pci_drive_t drive;
   logic       perr_n;
   logic       perr_oe;
   logic       serr_oe;
   logic       addr_phase;
   logic       wr_xfer;
   logic       wb_start;
   logic       wb_done;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;

   pci_pads u_pads (
      .pci_clk_i       (pci_clk_i),
      .reset_i         (reset_i),
      .pci_ad_io       (pci_ad_io),
      .pci_cbe_io      (pci_cbe_io),
      .pci_frame_n_io  (pci_frame_n_io),
      .pci_irdy_n_io   (pci_irdy_n_io),
      .pci_trdy_n_io   (pci_trdy_n_io),
      .pci_devsel_n_io (pci_devsel_n_io),
      .pci_stop_n_io   (pci_stop_n_io),
      .pci_par_io      (pci_par_io),
      .pci_perr_n_io   (pci_perr_n_io),
      .pci_serr_n_o    (pci_serr_n_o),
      .drive_i         (drive),
      .perr_n_i        (perr_n),
      .perr_oe_i       (perr_oe),
      .serr_oe_i       (serr_oe),
      .ad_o            (ad),
      .cbe_o           (cbe),
      .frame_n_o       (frame_n),
      .irdy_n_o        (irdy_n),
      .par_o           (par)
   );

   pci_target u_target (
      .pci_clk_i    (pci_clk_i),
      .reset_i      (reset_i),
      .ad_i         (ad),
      .cbe_i        (cbe),
      .frame_n_i    (frame_n),
      .irdy_n_i     (irdy_n),
      .drive_o      (drive),
      .wb_start_o   (wb_start),
      .wb_req_o     (wb_req),
      .wb_done_i    (wb_done),
      .wb_rsp_i     (wb_rsp),
      .addr_phase_o (addr_phase),
      .wr_xfer_o    (wr_xfer)
   );

   pci_parity_check u_parity (
      .pci_clk_i    (pci_clk_i),
      .reset_i      (reset_i),
      .ad_i         (ad),
      .cbe_i        (cbe),
      .par_i        (par),
      .addr_phase_i (addr_phase),
      .wr_xfer_i    (wr_xfer),
      .perr_n_o     (perr_n),
      .perr_oe_o    (perr_oe),
      .serr_oe_o    (serr_oe)
   );

   wb_master u_wb_master (
      .pci_clk_i (pci_clk_i),
      .reset_i   (reset_i),
      .start_i   (wb_start),
      .req_i     (wb_req),
      .done_o    (wb_done),
      .rsp_o     (wb_rsp),
      .wbm_cyc_o (wbm_cyc_o),
      .wbm_stb_o (wbm_stb_o),
      .wbm_we_o  (wbm_we_o),
      .wbm_adr_o (wbm_adr_o),
      .wbm_dat_o (wbm_dat_o),
      .wbm_sel_o (wbm_sel_o),
      .wbm_dat_i (wbm_dat_i),
      .wbm_ack_i (wbm_ack_i),
      .wbm_err_i (wbm_err_i),
      .wbm_rty_i (wbm_rty_i)
   );

endmodule

//--- hw/wb_master.sv
`timescale 1ns/1ps

module wb_master (
   input  logic                pci_clk_i,
   input  logic                reset_i,
   input  logic                start_i,
   input  wb_bus_pkg::wb_req_t req_i,
   output logic                done_o,
   output wb_bus_pkg::wb_rsp_t rsp_o,
   output logic                wbm_cyc_o,
   output logic                wbm_stb_o,
   output logic                wbm_we_o,
   output wb_bus_pkg::wb_adr_t wbm_adr_o,
   output wb_bus_pkg::wb_dat_t wbm_dat_o,
   output wb_bus_pkg::wb_sel_t wbm_sel_o,
   input  wb_bus_pkg::wb_dat_t wbm_dat_i,
   input  logic                wbm_ack_i,
   input  logic                wbm_err_i,
   input  logic                wbm_rty_i
);

   import wb_bus_pkg::*;

   wb_req_t req_q;
   logic    busy_q;
   logic    term;

   assign term = busy_q && (wbm_ack_i || wbm_err_i || wbm_rty_i);

   assign wbm_cyc_o = busy_q;
   assign wbm_stb_o = busy_q;
   assign wbm_we_o  = req_q.we;
   assign wbm_adr_o = req_q.adr;
   assign wbm_dat_o = req_q.dat;
   assign wbm_sel_o = req_q.sel;

   always_ff @(posedge pci_clk_i) begin
      if (start_i) begin
         req_q <= req_i;
      end
   end

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         busy_q <= 1'b0;
         done_o <= 1'b0;
         rsp_o  <= '0;
      end else begin
         done_o <= term;
         if (start_i) begin
            busy_q <= 1'b1;
         end else if (term) begin
            busy_q    <= 1'b0;
            rsp_o.dat <= wbm_dat_i;
            rsp_o.ack <= wbm_ack_i;
            rsp_o.err <= wbm_err_i && !wbm_ack_i;
            rsp_o.rty <= wbm_rty_i && !wbm_ack_i && !wbm_err_i;
         end
      end
   end

   // Relies on the target never starting while a cycle is open
   a_req_stable: assert property (@(posedge pci_clk_i) disable iff (reset_i)
      (wbm_stb_o && !term) |=> $stable({wbm_adr_o, wbm_we_o, wbm_sel_o}));

endmodule

//--- hw/pci_parity_check.sv
`timescale 1ns/1ps

module pci_parity_check (
   input  logic                  pci_clk_i,
   input  logic                  reset_i,
   input  pci_bus_pkg::pci_ad_t  ad_i,
   input  pci_bus_pkg::pci_cbe_t cbe_i,
   input  logic                  par_i,
   input  logic                  addr_phase_i,
   input  logic                  wr_xfer_i,
   output logic                  perr_n_o,
   output logic                  perr_oe_o,
   output logic                  serr_oe_o
);

   logic par_calc_q;
   logic chk_addr_q;
   logic chk_data_q;
   logic par_bad;

   // PAR arrives one clock after the phase it covers
   assign par_bad = (par_i != par_calc_q);

   always_ff @(posedge pci_clk_i) begin
      par_calc_q <= ^{ad_i, cbe_i};
   end

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         chk_addr_q <= 1'b0;
         chk_data_q <= 1'b0;
         perr_n_o   <= 1'b1;
         perr_oe_o  <= 1'b0;
         serr_oe_o  <= 1'b0;
      end else begin
         chk_addr_q <= addr_phase_i;
         chk_data_q <= wr_xfer_i;
         serr_oe_o  <= chk_addr_q && par_bad;
         // PERR# low for one clock, then high for one clock, then released
         if (chk_data_q && par_bad) begin
            perr_n_o  <= 1'b0;
            perr_oe_o <= 1'b1;
         end else if (perr_oe_o && !perr_n_o) begin
            perr_n_o <= 1'b1;
         end else begin
            perr_n_o  <= 1'b1;
            perr_oe_o <= 1'b0;
         end
      end
   end

endmodule

//--- hw/pci_target.sv
`timescale 1ns/1ps

module pci_target (
   input  logic                    pci_clk_i,
   input  logic                    reset_i,
   input  pci_bus_pkg::pci_ad_t    ad_i,
   input  pci_bus_pkg::pci_cbe_t   cbe_i,
   input  logic                    frame_n_i,
   input  logic                    irdy_n_i,
   output pci_bus_pkg::pci_drive_t drive_o,
   output logic                    wb_start_o,
   output wb_bus_pkg::wb_req_t     wb_req_o,
   input  logic                    wb_done_i,
   input  wb_bus_pkg::wb_rsp_t     wb_rsp_i,
   output logic                    addr_phase_o,
   output logic                    wr_xfer_o
);

   import pci_bus_pkg::*;
   import wb_bus_pkg::*;

   target_state_e state_q;
   pci_ad_t       adr_q;
   pci_cmd_e      cmd_q;
   logic          frame_q;
   logic          claimed_q;
   logic          hit;
   logic          is_write;

   // Address phase is FRAME# falling while idle
   assign addr_phase_o = (state_q == IDLE) && frame_q && !frame_n_i;

   assign is_write = (cmd_q == CMD_MEM_WRITE);
   assign hit      = ((adr_q & BAR_MASK) == BAR_BASE) &&
                     (cmd_q == CMD_MEM_READ || cmd_q == CMD_MEM_WRITE);

   // Writes wait for IRDY# so that AD holds valid data
   assign wb_start_o = (state_q == DECODE) && claimed_q && (!is_write || !irdy_n_i);

   assign wb_req_o.adr = adr_q & ~BAR_MASK;
   assign wb_req_o.dat = ad_i;
   assign wb_req_o.sel = ~cbe_i;
   assign wb_req_o.we  = is_write;

   assign wr_xfer_o = (state_q == DATA) && is_write && !irdy_n_i;

   always_ff @(posedge pci_clk_i) begin
      if (addr_phase_o) begin
         adr_q <= ad_i;
         cmd_q <= pci_cmd_e'(cbe_i);
      end
   end

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         state_q   <= IDLE;
         frame_q   <= 1'b1;
         claimed_q <= 1'b0;
         drive_o   <= DRIVE_IDLE;
      end else begin
         frame_q <= frame_n_i;
         case (state_q)
            IDLE: begin
               if (addr_phase_o) begin
                  state_q   <= DECODE;
                  claimed_q <= 1'b0;
               end
            end
            DECODE: begin
               // Medium decode, claim on the clock after the address phase
               if (!claimed_q) begin
                  if (hit) begin
                     claimed_q         <= 1'b1;
                     drive_o.devsel_n  <= 1'b0;
                     drive_o.devsel_oe <= 1'b1;
                     drive_o.trdy_oe   <= 1'b1;
                     drive_o.stop_oe   <= 1'b1;
                  end else begin
                     // Miss, let the initiator master-abort
                     state_q <= IDLE;
                  end
               end else if (wb_start_o) begin
                  state_q <= WB_WAIT;
               end
            end
            WB_WAIT: begin
               if (wb_done_i) begin
                  if (wb_rsp_i.ack) begin
                     state_q        <= DATA;
                     drive_o.trdy_n <= 1'b0;
                     // Burst still going, so disconnect with data
                     drive_o.stop_n <= frame_n_i;
                     drive_o.ad     <= wb_rsp_i.dat;
                     drive_o.ad_oe  <= !is_write;
                  end else if (wb_rsp_i.rty) begin
                     state_q        <= RETRY;
                     drive_o.stop_n <= 1'b0;
                  end else begin
                     state_q          <= ABORT;
                     drive_o.stop_n   <= 1'b0;
                     drive_o.devsel_n <= 1'b1;
                  end
               end
            end
            DATA: begin
               if (!irdy_n_i) begin
                  drive_o.trdy_n <= 1'b1;
                  drive_o.ad_oe  <= 1'b0;
                  if (frame_n_i) begin
                     state_q          <= TURN;
                     drive_o.stop_n   <= 1'b1;
                     drive_o.devsel_n <= 1'b1;
                  end else begin
                     // Hold STOP# like a retry until FRAME# goes high
                     state_q        <= RETRY;
                     drive_o.stop_n <= 1'b0;
                  end
               end
            end
            RETRY, ABORT: begin
               if (frame_n_i) begin
                  state_q          <= TURN;
                  drive_o.stop_n   <= 1'b1;
                  drive_o.devsel_n <= 1'b1;
               end
            end
            TURN: begin
               state_q <= IDLE;
               drive_o <= DRIVE_IDLE;
            end
            default: begin
               state_q <= IDLE;
               drive_o <= DRIVE_IDLE;
            end
         endcase
      end
   end

   a_trdy_with_devsel: assert property (@(posedge pci_clk_i) disable iff (reset_i)
      (drive_o.trdy_oe && !drive_o.trdy_n) |-> (drive_o.devsel_oe && !drive_o.devsel_n));

   // One request outstanding until the Wishbone side reports done
   a_done_in_wait: assert property (@(posedge pci_clk_i) disable iff (reset_i)
      wb_done_i |-> (state_q == WB_WAIT));

endmodule

//--- hw/pci_pads.sv
`timescale 1ns/1ps

module pci_pads (
   input  logic                    pci_clk_i,
   input  logic                    reset_i,
   inout  wire  [31:0]             pci_ad_io,
   inout  wire  [3:0]              pci_cbe_io,
   inout  wire                     pci_frame_n_io,
   inout  wire                     pci_irdy_n_io,
   inout  wire                     pci_trdy_n_io,
   inout  wire                     pci_devsel_n_io,
   inout  wire                     pci_stop_n_io,
   inout  wire                     pci_par_io,
   inout  wire                     pci_perr_n_io,
   output wire                     pci_serr_n_o,
   input  pci_bus_pkg::pci_drive_t drive_i,
   input  logic                    perr_n_i,
   input  logic                    perr_oe_i,
   input  logic                    serr_oe_i,
   output pci_bus_pkg::pci_ad_t    ad_o,
   output pci_bus_pkg::pci_cbe_t   cbe_o,
   output logic                    frame_n_o,
   output logic                    irdy_n_o,
   output logic                    par_o
);

   logic par_q;
   logic par_oe_q;

   // Sampled pin values
   assign ad_o      = pci_ad_io;
   assign cbe_o     = pci_cbe_io;
   assign frame_n_o = pci_frame_n_io;
   assign irdy_n_o  = pci_irdy_n_io;
   assign par_o     = pci_par_io;

   assign pci_ad_io       = drive_i.ad_oe     ? drive_i.ad       : 'z;
   assign pci_trdy_n_io   = drive_i.trdy_oe   ? drive_i.trdy_n   : 1'bz;
   assign pci_stop_n_io   = drive_i.stop_oe   ? drive_i.stop_n   : 1'bz;
   assign pci_devsel_n_io = drive_i.devsel_oe ? drive_i.devsel_n : 1'bz;
   assign pci_par_io      = par_oe_q          ? par_q            : 1'bz;
   assign pci_perr_n_io   = perr_oe_i         ? perr_n_i         : 1'bz;

   // Open drain
   assign pci_serr_n_o    = serr_oe_i ? 1'b0 : 1'bz;

   // Even parity over the driven AD and the initiator's byte enables
   always_ff @(posedge pci_clk_i) begin
      par_q <= ^{drive_i.ad, cbe_o};
   end

   always_ff @(posedge pci_clk_i) begin
      if (reset_i) begin
         par_oe_q <= 1'b0;
      end else begin
         par_oe_q <= drive_i.ad_oe;
      end
   end

   // PAR on the pin covers the AD and C/BE# seen one clock earlier
   a_par_matches_bus: assert property (@(posedge pci_clk_i) disable iff (reset_i)
      par_oe_q |-> (pci_par_io === $past(^{pci_ad_io, pci_cbe_io})));

endmodule

//--- hw/wb_bus_pkg.sv
package wb_bus_pkg;

   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;
   localparam int WB_SEL_W = WB_DAT_W / 8;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_dat_t;
   typedef logic [WB_SEL_W-1:0] wb_sel_t;

   // One classic cycle as requested by the PCI side
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    we;
   } wb_req_t;

   // Read data and how the slave terminated the cycle
   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
      logic    err;
      logic    rty;
   } wb_rsp_t;

endpackage

//--- hw/pci_bus_pkg.sv
package pci_bus_pkg;

   typedef logic [31:0] pci_ad_t;
   typedef logic [3:0]  pci_cbe_t;

   // Bus commands on C/BE# during the address phase
   typedef enum logic [3:0] {
      CMD_IO_READ   = 4'b0010,
      CMD_IO_WRITE  = 4'b0011,
      CMD_MEM_READ  = 4'b0110,
      CMD_MEM_WRITE = 4'b0111
   } pci_cmd_e;

   typedef enum logic [2:0] {
      IDLE,
      DECODE,
      WB_WAIT,
      DATA,
      RETRY,
      ABORT,
      TURN
   } target_state_e;

   // Target outputs toward the pads
   typedef struct packed {
      pci_ad_t ad;
      logic    ad_oe;
      logic    trdy_n;
      logic    stop_n;
      logic    devsel_n;
      logic    trdy_oe;
      logic    stop_oe;
      logic    devsel_oe;
   } pci_drive_t;

   localparam pci_drive_t DRIVE_IDLE = '{
      ad: '0, ad_oe: 1'b0,
      trdy_n: 1'b1, stop_n: 1'b1, devsel_n: 1'b1,
      trdy_oe: 1'b0, stop_oe: 1'b0, devsel_oe: 1'b0
   };

   // Memory window, 4 KiB
   localparam pci_ad_t BAR_BASE = 32'h8000_0000;
   localparam pci_ad_t BAR_MASK = 32'hFFFF_F000;

   // Medium decode
   localparam int DEVSEL_DELAY = 2;

endpackage
